//--- Bender.yml
package:
  name: ir_decode

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/mips_decode_pkg.sv
      - source/decode_if.sv
      - source/instr_classify.sv
      - source/field_extract.sv
      - source/decode_stage.sv
      - source/wb_ctrl.sv
      - source/ir_decode.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/ir_decode_chk.sv
      - test/ir_decode_tb.sv

//--- source/decode_if.sv
// one decoded instruction, from a decode stage to whatever reads it
interface decode_if;

    mips_decode_pkg::instr_code_t  code;
    mips_decode_pkg::instr_fmt_t   fmt;
    mips_decode_pkg::reg_idx_t     rs;
    mips_decode_pkg::reg_idx_t     rt;
    mips_decode_pkg::reg_idx_t     rd;     // R format only
    mips_decode_pkg::reg_idx_t     shamt;  // R format only
    mips_decode_pkg::imm_t         imm;    // I format only
    mips_decode_pkg::jump_target_t target; // J format only

    modport producer (
        output code, fmt, rs, rt, rd, shamt, imm, target
    );

    modport consumer (
        input code, fmt, rs, rt, rd, shamt, imm, target
    );

endinterface

//--- source/decode_stage.sv
module decode_stage #(
    parameter int REGISTERED = 0  // 1 puts the instruction register in front
) (
    input  logic                         clk,
    input  logic                         i_arst_n,
    input  mips_decode_pkg::instr_word_t i_instr,
    input  logic                         i_instr_valid,
    decode_if.producer                   dec
);

    mips_decode_pkg::instr_word_t instr; // word being decoded
    mips_decode_pkg::instr_code_t code;
    mips_decode_pkg::instr_fmt_t  fmt;

    generate
        if (REGISTERED != 0) begin : g_ir
            mips_decode_pkg::instr_word_t ir_q;

            // zero decodes as sll r0, which never writes
            always_ff @(posedge clk or negedge i_arst_n) begin
                if (!i_arst_n) begin
                    ir_q <= '0;
                end else if (i_instr_valid) begin
                    ir_q <= i_instr;
                end
            end

            assign instr = ir_q;
        end else begin : g_live
            assign instr = i_instr;
        end
    endgenerate

    instr_classify u_classify (
        .i_instr (instr),
        .o_code  (code),
        .o_fmt   (fmt)
    );

    field_extract u_extract (
        .i_instr (instr),
        .i_code  (code),
        .i_fmt   (fmt),
        .dec     (dec)
    );

endmodule

//--- source/field_extract.sv
`include "mips_decode_defs.svh"

module field_extract (
    input  mips_decode_pkg::instr_word_t i_instr,
    input  mips_decode_pkg::instr_code_t i_code,
    input  mips_decode_pkg::instr_fmt_t  i_fmt,
    decode_if.producer                   dec
);

    localparam int EXT_W = `WORD_W - `IMM_W; // bits added by extension

    logic [`IMM_W-1:0] imm16;

    assign imm16 = i_instr[`IMM_W-1:0];

    always_comb begin
        dec.code   = i_code;
        dec.fmt    = i_fmt;
        // fields not used by the format read as zero
        dec.rs     = '0;
        dec.rt     = '0;
        dec.rd     = '0;
        dec.shamt  = '0;
        dec.imm    = '0;
        dec.target = '0;
        case (i_fmt)
            mips_decode_pkg::FMT_R: begin
                dec.rs    = i_instr[`RS_LSB +: `REG_IDX_W];
                dec.rt    = i_instr[`RT_LSB +: `REG_IDX_W];
                dec.rd    = i_instr[`RD_LSB +: `REG_IDX_W];
                dec.shamt = i_instr[`SHAMT_LSB +: `REG_IDX_W];
            end
            mips_decode_pkg::FMT_J: begin
                dec.target = i_instr[`TARGET_W-1:0];
            end
            default: begin
                dec.rs = i_instr[`RS_LSB +: `REG_IDX_W];
                dec.rt = i_instr[`RT_LSB +: `REG_IDX_W];
                case (i_code)
                    mips_decode_pkg::ANDI,
                    mips_decode_pkg::ORI,
                    mips_decode_pkg::XORI: dec.imm = {{EXT_W{1'b0}}, imm16}; // logical ops
                    mips_decode_pkg::LUI:  dec.imm = {imm16, {EXT_W{1'b0}}};
                    default:               dec.imm = {{EXT_W{imm16[`IMM_W-1]}}, imm16};
                endcase
            end
        endcase
    end

endmodule

//--- source/instr_classify.sv
`include "mips_decode_defs.svh"

module instr_classify (
    input  mips_decode_pkg::instr_word_t i_instr,
    output mips_decode_pkg::instr_code_t o_code,
    output mips_decode_pkg::instr_fmt_t  o_fmt
);

    logic [`OPC_W-1:0]         opc;
    logic [`FUNCT_W-1:0]       funct;
    mips_decode_pkg::reg_idx_t rt;

    assign opc   = i_instr[`INSTR_W-1 -: `OPC_W];
    assign funct = i_instr[`FUNCT_W-1:0];
    assign rt    = i_instr[`RT_LSB +: `REG_IDX_W];

    always_comb begin
        case (opc)
            `OPC_SPECIAL:     o_fmt = mips_decode_pkg::FMT_R;
            `OPC_J, `OPC_JAL: o_fmt = mips_decode_pkg::FMT_J;
            default:          o_fmt = mips_decode_pkg::FMT_I;
        endcase
    end

    always_comb begin
        o_code = mips_decode_pkg::INVALID; // anything not matched below
        case (opc)
            `OPC_SPECIAL: begin
                case (funct)
                    `FN_SLL:   o_code = mips_decode_pkg::SLL;
                    `FN_SRL:   o_code = mips_decode_pkg::SRL;
                    `FN_SRA:   o_code = mips_decode_pkg::SRA;
                    `FN_SLLV:  o_code = mips_decode_pkg::SLLV;
                    `FN_SRLV:  o_code = mips_decode_pkg::SRLV;
                    `FN_SRAV:  o_code = mips_decode_pkg::SRAV;
                    `FN_JR:    o_code = mips_decode_pkg::JR;
                    `FN_JALR:  o_code = mips_decode_pkg::JALR;
                    `FN_MFHI:  o_code = mips_decode_pkg::MFHI;
                    `FN_MTHI:  o_code = mips_decode_pkg::MTHI;
                    `FN_MFLO:  o_code = mips_decode_pkg::MFLO;
                    `FN_MTLO:  o_code = mips_decode_pkg::MTLO;
                    `FN_MULT:  o_code = mips_decode_pkg::MULT;
                    `FN_MULTU: o_code = mips_decode_pkg::MULTU;
                    `FN_DIV:   o_code = mips_decode_pkg::DIV;
                    `FN_DIVU:  o_code = mips_decode_pkg::DIVU;
                    `FN_ADD:   o_code = mips_decode_pkg::ADD;
                    `FN_ADDU:  o_code = mips_decode_pkg::ADDU;
                    `FN_SUBU:  o_code = mips_decode_pkg::SUBU;
                    `FN_AND:   o_code = mips_decode_pkg::AND;
                    `FN_OR:    o_code = mips_decode_pkg::OR;
                    `FN_XOR:   o_code = mips_decode_pkg::XOR;
                    `FN_SLT:   o_code = mips_decode_pkg::SLT;
                    `FN_SLTU:  o_code = mips_decode_pkg::SLTU;
                    default:   o_code = mips_decode_pkg::INVALID;
                endcase
            end
            `OPC_REGIMM: begin
                // the branch kind sits in the rt field
                case (rt)
                    `RT_BLTZ:   o_code = mips_decode_pkg::BLTZ;
                    `RT_BGEZ:   o_code = mips_decode_pkg::BGEZ;
                    `RT_BLTZAL: o_code = mips_decode_pkg::BLTZAL;
                    `RT_BGEZAL: o_code = mips_decode_pkg::BGEZAL;
                    default:    o_code = mips_decode_pkg::INVALID;
                endcase
            end
            `OPC_J:     o_code = mips_decode_pkg::J;
            `OPC_JAL:   o_code = mips_decode_pkg::JAL;
            `OPC_BEQ:   o_code = mips_decode_pkg::BEQ;
            `OPC_BNE:   o_code = mips_decode_pkg::BNE;
            `OPC_BLEZ:  o_code = mips_decode_pkg::BLEZ;
            `OPC_BGTZ:  o_code = mips_decode_pkg::BGTZ;
            `OPC_ADDI:  o_code = mips_decode_pkg::ADDI;
            `OPC_ADDIU: o_code = mips_decode_pkg::ADDIU;
            `OPC_SLTI:  o_code = mips_decode_pkg::SLTI;
            `OPC_SLTIU: o_code = mips_decode_pkg::SLTIU;
            `OPC_ANDI:  o_code = mips_decode_pkg::ANDI;
            `OPC_ORI:   o_code = mips_decode_pkg::ORI;
            `OPC_XORI:  o_code = mips_decode_pkg::XORI;
            `OPC_LUI:   o_code = mips_decode_pkg::LUI;
            `OPC_LB:    o_code = mips_decode_pkg::LB;
            `OPC_LH:    o_code = mips_decode_pkg::LH;
            `OPC_LWL:   o_code = mips_decode_pkg::LWL;
            `OPC_LW:    o_code = mips_decode_pkg::LW;
            `OPC_LBU:   o_code = mips_decode_pkg::LBU;
            `OPC_LHU:   o_code = mips_decode_pkg::LHU;
            `OPC_LWR:   o_code = mips_decode_pkg::LWR;
            `OPC_SB:    o_code = mips_decode_pkg::SB;
            `OPC_SH:    o_code = mips_decode_pkg::SH;
            `OPC_SW:    o_code = mips_decode_pkg::SW;
            default:    o_code = mips_decode_pkg::INVALID;
        endcase
    end

endmodule

//--- source/ir_decode.sv
module ir_decode (
    input  logic                          clk,
    input  logic                          i_arst_n,
    input  mips_decode_pkg::instr_word_t  i_instr,
    input  logic                          i_instr_valid,

    // stage 1, straight from the bus
    output mips_decode_pkg::instr_code_t  o_code_1,
    output mips_decode_pkg::reg_idx_t     o_rs_1,
    output mips_decode_pkg::reg_idx_t     o_rt_1,
    output mips_decode_pkg::imm_t         o_imm_1,
    output mips_decode_pkg::jump_target_t o_jump_target,

    // stage 2, from the instruction register
    output mips_decode_pkg::instr_code_t  o_code_2,
    output mips_decode_pkg::reg_idx_t     o_rs_2,
    output mips_decode_pkg::reg_idx_t     o_rt_2,
    output mips_decode_pkg::reg_idx_t     o_shamt,
    output mips_decode_pkg::imm_t         o_imm_2,
    output mips_decode_pkg::reg_idx_t     o_dest_reg,
    output logic                          o_reg_write_en
);

    decode_if dec_1 ();
    decode_if dec_2 ();

    decode_stage #(.REGISTERED(0)) u_stage1 (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_instr       (i_instr),
        .i_instr_valid (i_instr_valid),
        .dec           (dec_1.producer)
    );

    decode_stage #(.REGISTERED(1)) u_stage2 (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_instr       (i_instr),
        .i_instr_valid (i_instr_valid),
        .dec           (dec_2.producer)
    );

    wb_ctrl u_wb (
        .dec            (dec_2.consumer),
        .o_dest_reg     (o_dest_reg),
        .o_reg_write_en (o_reg_write_en)
    );

    assign o_code_1      = dec_1.code;
    assign o_rs_1        = dec_1.rs;
    assign o_rt_1        = dec_1.rt;
    assign o_imm_1       = dec_1.imm;
    assign o_jump_target = dec_1.target;

    assign o_code_2      = dec_2.code;
    assign o_rs_2        = dec_2.rs;
    assign o_rt_2        = dec_2.rt;
    assign o_shamt       = dec_2.shamt;
    assign o_imm_2       = dec_2.imm;

endmodule

//--- source/mips_decode_defs.svh
`ifndef MIPS_DECODE_DEFS_SVH
`define MIPS_DECODE_DEFS_SVH

// field widths
`define INSTR_W    32
`define WORD_W     32  // width of the extended immediate
`define REG_IDX_W  5
`define IMM_W      16
`define TARGET_W   26
`define OPC_W      6
`define FUNCT_W    6
`define CODE_W     7

// field positions inside the instruction word
`define RS_LSB     21
`define RT_LSB     16
`define RD_LSB     11
`define SHAMT_LSB  6

// primary opcodes, bits 31:26
`define OPC_SPECIAL 6'h00  // R format, function field selects the op
`define OPC_REGIMM  6'h01  // branches selected by rt
`define OPC_J       6'h02
`define OPC_JAL     6'h03
`define OPC_BEQ     6'h04
`define OPC_BNE     6'h05
`define OPC_BLEZ    6'h06
`define OPC_BGTZ    6'h07
`define OPC_ADDI    6'h08
`define OPC_ADDIU   6'h09
`define OPC_SLTI    6'h0a
`define OPC_SLTIU   6'h0b
`define OPC_ANDI    6'h0c
`define OPC_ORI     6'h0d
`define OPC_XORI    6'h0e
`define OPC_LUI     6'h0f
`define OPC_LB      6'h20
`define OPC_LH      6'h21
`define OPC_LWL     6'h22
`define OPC_LW      6'h23
`define OPC_LBU     6'h24
`define OPC_LHU     6'h25
`define OPC_LWR     6'h26
`define OPC_SB      6'h28
`define OPC_SH      6'h29
`define OPC_SW      6'h2b

// function codes under OPC_SPECIAL, bits 5:0
`define FN_SLL      6'h00
`define FN_SRL      6'h02
`define FN_SRA      6'h03
`define FN_SLLV     6'h04
`define FN_SRLV     6'h06
`define FN_SRAV     6'h07
`define FN_JR       6'h08
`define FN_JALR     6'h09
`define FN_MFHI     6'h10
`define FN_MTHI     6'h11
`define FN_MFLO     6'h12
`define FN_MTLO     6'h13
`define FN_MULT     6'h18
`define FN_MULTU    6'h19
`define FN_DIV      6'h1a
`define FN_DIVU     6'h1b
`define FN_ADD      6'h20
`define FN_ADDU     6'h21
`define FN_SUBU     6'h23
`define FN_AND      6'h24
`define FN_OR       6'h25
`define FN_XOR      6'h26
`define FN_SLT      6'h2a
`define FN_SLTU     6'h2b

// rt values under OPC_REGIMM
`define RT_BLTZ     5'h00
`define RT_BGEZ     5'h01
`define RT_BLTZAL   5'h10
`define RT_BGEZAL   5'h11

`define LINK_REG    5'd31  // return address register for the linking jumps

`endif

//--- source/mips_decode_pkg.sv
`include "mips_decode_defs.svh"

package mips_decode_pkg;

    typedef logic [`INSTR_W-1:0]   instr_word_t;
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;      // register index, also shift amount
    typedef logic [`WORD_W-1:0]    imm_t;          // immediate after extension
    typedef logic [`TARGET_W-1:0]  jump_target_t;

    // INVALID is 0, the rest count up from ADD in this order
    typedef enum logic [`CODE_W-1:0] {
        INVALID = 7'd0,
        // alu
        ADD = 7'd1,
        ADDI, ADDIU, ADDU, AND, ANDI,
        DIV, DIVU, MFHI, MFLO, MTHI, MTLO,
        MULT, MULTU, OR, ORI, SLL, SLLV,
        SLT, SLTI, SLTIU, SLTU, SRA, SRAV,
        SRL, SRLV, SUBU, XOR, XORI,
        // branches and jumps, BEQ is 30
        BEQ, BGEZ, BGEZAL, BGTZ, BLEZ, BLTZ,
        BLTZAL, BNE, J, JAL, JALR, JR,
        // memory, LB is 42 and SW is 52
        LB, LBU, LH, LHU, LUI, LW,
        LWL, LWR, SB, SH, SW
    } instr_code_t;

    typedef enum logic [1:0] {
        FMT_R = 2'd0,
        FMT_I = 2'd1,
        FMT_J = 2'd2
    } instr_fmt_t;

endpackage

//--- source/wb_ctrl.sv
`include "mips_decode_defs.svh"

module wb_ctrl (
    decode_if.consumer                dec,
    output mips_decode_pkg::reg_idx_t o_dest_reg,
    output logic                      o_reg_write_en
);

    logic wants_write; // before the r0 check

    always_comb begin
        case (dec.fmt)
            mips_decode_pkg::FMT_R: o_dest_reg = dec.rd;
            mips_decode_pkg::FMT_J: o_dest_reg = (dec.code == mips_decode_pkg::JAL) ?
                                                 `LINK_REG : '0;
            default: begin
                if (dec.code == mips_decode_pkg::BGEZAL || dec.code == mips_decode_pkg::BLTZAL)
                    o_dest_reg = `LINK_REG;
                else
                    o_dest_reg = dec.rt;
            end
        endcase
    end

    always_comb begin
        case (dec.code)
            // results go to hi/lo or nowhere
            mips_decode_pkg::MTHI, mips_decode_pkg::MTLO, mips_decode_pkg::JR,
            mips_decode_pkg::MULT, mips_decode_pkg::MULTU,
            mips_decode_pkg::DIV, mips_decode_pkg::DIVU: wants_write = 1'b0;
            mips_decode_pkg::JAL, mips_decode_pkg::BGEZAL, mips_decode_pkg::BLTZAL,
            mips_decode_pkg::LB, mips_decode_pkg::LBU, mips_decode_pkg::LH,
            mips_decode_pkg::LHU, mips_decode_pkg::LW, mips_decode_pkg::LWL,
            mips_decode_pkg::LWR, mips_decode_pkg::LUI,
            mips_decode_pkg::ADDI, mips_decode_pkg::ADDIU, mips_decode_pkg::ANDI,
            mips_decode_pkg::ORI, mips_decode_pkg::XORI,
            mips_decode_pkg::SLTI, mips_decode_pkg::SLTIU: wants_write = 1'b1;
            default: wants_write = (dec.fmt == mips_decode_pkg::FMT_R); // also unknown R words
        endcase
    end

    assign o_reg_write_en = wants_write && (o_dest_reg != '0); // r0 is hardwired

endmodule

//--- tb.f
+incdir+source
source/mips_decode_pkg.sv
source/decode_if.sv
source/instr_classify.sv
source/field_extract.sv
source/decode_stage.sv
source/wb_ctrl.sv
source/ir_decode.sv
test/ir_decode_chk.sv
test/ir_decode_tb.sv

//--- test/ir_decode_chk.sv
`include "mips_decode_defs.svh"

module ir_decode_chk (
    input logic                         clk,
    input logic                         i_arst_n,
    input logic                         i_instr_valid,
    input mips_decode_pkg::instr_code_t o_code_1,
    input mips_decode_pkg::instr_code_t o_code_2,
    input mips_decode_pkg::reg_idx_t    o_rs_2,
    input mips_decode_pkg::reg_idx_t    o_rt_2,
    input mips_decode_pkg::reg_idx_t    o_shamt,
    input mips_decode_pkg::imm_t        o_imm_2,
    input mips_decode_pkg::reg_idx_t    o_dest_reg,
    input logic                         o_reg_write_en
);

    int fail_cnt = 0; // failed assertions so far

    // r0 is never a write target
    a_we_dest: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_reg_write_en |-> o_dest_reg != `REG_IDX_W'd0)
        else begin
            fail_cnt++;
            $error("write enable raised with destination register 0");
        end

    a_code_follows: assert property (@(posedge clk) disable iff (!i_arst_n)
        $past(i_instr_valid) |-> o_code_2 == $past(o_code_1))
        else begin
            fail_cnt++;
            $error("stage 2 code does not match the word loaded one cycle earlier");
        end

    a_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
        !$past(i_instr_valid) |-> $stable(o_code_2) && $stable(o_rs_2) && $stable(o_rt_2)
            && $stable(o_shamt) && $stable(o_imm_2) && $stable(o_dest_reg)
            && $stable(o_reg_write_en))
        else begin
            fail_cnt++;
            $error("stage 2 outputs changed without a valid word");
        end

    a_reset_we: assert property (@(posedge clk) !i_arst_n |-> !o_reg_write_en)
        else begin
            fail_cnt++;
            $error("write enable high during reset");
        end

endmodule

//--- test/ir_decode_tb.sv
`include "mips_decode_defs.svh"

module ir_decode_tb;

    localparam int          NUM_CYCLES     = 2000;
    localparam int          RESET_CYCLES   = 4;
    localparam int          TIMEOUT_CYCLES = NUM_CYCLES + RESET_CYCLES + 100;
    localparam logic [31:0] SEED           = 32'he66becd1;

    logic                                  clk = 1'b0;
    logic                                  i_arst_n;
    mips_decode_pkg::instr_word_t          i_instr;
    logic                                  i_instr_valid;
    mips_decode_pkg::instr_code_t          o_code_1, o_code_2;
    mips_decode_pkg::reg_idx_t             o_rs_1, o_rt_1, o_rs_2, o_rt_2, o_shamt, o_dest_reg;
    mips_decode_pkg::imm_t                 o_imm_1, o_imm_2;
    mips_decode_pkg::jump_target_t         o_jump_target;
    logic                                  o_reg_write_en;

    mips_decode_pkg::instr_word_t          model_ir = '0; // reference copy of the register
    mips_decode_pkg::instr_code_t          e_code;
    mips_decode_pkg::reg_idx_t             e_rs, e_rt, e_shamt, e_dest;
    mips_decode_pkg::imm_t                 e_imm;
    mips_decode_pkg::jump_target_t         e_target;
    logic                                  e_we;
    int                                    errors = 0;
    int                                    checks = 0;
    int                                    cycle_cnt;

    // key per code in enum order, {class, value}
    // class 0 is the opcode, 1 the function field, 2 the rt field under REGIMM
    logic [7:0] code_key [1:52] = '{
        {2'd1, `FN_ADD}, {2'd0, `OPC_ADDI}, {2'd0, `OPC_ADDIU}, {2'd1, `FN_ADDU},
        {2'd1, `FN_AND}, {2'd0, `OPC_ANDI}, {2'd1, `FN_DIV}, {2'd1, `FN_DIVU},
        {2'd1, `FN_MFHI}, {2'd1, `FN_MFLO}, {2'd1, `FN_MTHI}, {2'd1, `FN_MTLO},
        {2'd1, `FN_MULT}, {2'd1, `FN_MULTU}, {2'd1, `FN_OR}, {2'd0, `OPC_ORI},
        {2'd1, `FN_SLL}, {2'd1, `FN_SLLV}, {2'd1, `FN_SLT}, {2'd0, `OPC_SLTI},
        {2'd0, `OPC_SLTIU}, {2'd1, `FN_SLTU}, {2'd1, `FN_SRA}, {2'd1, `FN_SRAV},
        {2'd1, `FN_SRL}, {2'd1, `FN_SRLV}, {2'd1, `FN_SUBU}, {2'd1, `FN_XOR},
        {2'd0, `OPC_XORI},
        {2'd0, `OPC_BEQ}, {2'd2, 1'b0, `RT_BGEZ}, {2'd2, 1'b0, `RT_BGEZAL},
        {2'd0, `OPC_BGTZ}, {2'd0, `OPC_BLEZ}, {2'd2, 1'b0, `RT_BLTZ},
        {2'd2, 1'b0, `RT_BLTZAL}, {2'd0, `OPC_BNE}, {2'd0, `OPC_J}, {2'd0, `OPC_JAL},
        {2'd1, `FN_JALR}, {2'd1, `FN_JR},
        {2'd0, `OPC_LB}, {2'd0, `OPC_LBU}, {2'd0, `OPC_LH}, {2'd0, `OPC_LHU},
        {2'd0, `OPC_LUI}, {2'd0, `OPC_LW}, {2'd0, `OPC_LWL}, {2'd0, `OPC_LWR},
        {2'd0, `OPC_SB}, {2'd0, `OPC_SH}, {2'd0, `OPC_SW}
    };

    ir_decode uut (.*);

    bind ir_decode ir_decode_chk u_chk (
        .clk (clk), .i_arst_n (i_arst_n), .i_instr_valid (i_instr_valid),
        .o_code_1 (o_code_1), .o_code_2 (o_code_2), .o_rs_2 (o_rs_2), .o_rt_2 (o_rt_2),
        .o_shamt (o_shamt), .o_imm_2 (o_imm_2), .o_dest_reg (o_dest_reg),
        .o_reg_write_en (o_reg_write_en)
    );

    initial begin
        forever #2 clk = ~clk;
    end

    function automatic mips_decode_pkg::instr_code_t code_of(mips_decode_pkg::instr_word_t w);
        logic hit;
        for (int k = 1; k <= 52; k++) begin
            case (code_key[k][7:6])
                2'd0:    hit = (w[31:26] == code_key[k][5:0]);
                2'd1:    hit = (w[31:26] == `OPC_SPECIAL) && (w[5:0] == code_key[k][5:0]);
                default: hit = (w[31:26] == `OPC_REGIMM) && (w[20:16] == code_key[k][4:0]);
            endcase
            if (hit)
                return mips_decode_pkg::instr_code_t'(k);
        end
        return mips_decode_pkg::INVALID; // no table entry matches
    endfunction

    task automatic ref_decode(
        input  mips_decode_pkg::instr_word_t  w,
        output mips_decode_pkg::instr_code_t  code,
        output mips_decode_pkg::reg_idx_t     rs, rt, shamt, dest,
        output mips_decode_pkg::imm_t         imm,
        output mips_decode_pkg::jump_target_t target,
        output logic                          we
    );
        logic is_r;
        logic is_j;
        is_r   = (w[31:26] == 6'h00);
        is_j   = (w[31:26] == 6'h02) || (w[31:26] == 6'h03);
        code   = code_of(w);
        rs     = is_j ? '0 : w[25:21];
        rt     = is_j ? '0 : w[20:16];
        shamt  = is_r ? w[10:6] : '0;
        target = is_j ? w[25:0] : '0;
        if (is_r || is_j)
            imm = '0;
        else if (code inside {mips_decode_pkg::ANDI, mips_decode_pkg::ORI, mips_decode_pkg::XORI})
            imm = {16'h0000, w[15:0]};
        else if (code == mips_decode_pkg::LUI)
            imm = {w[15:0], 16'h0000};
        else
            imm = {{16{w[15]}}, w[15:0]};
        if (is_r)
            dest = w[15:11];
        else if (code inside {mips_decode_pkg::JAL, mips_decode_pkg::BGEZAL,
                              mips_decode_pkg::BLTZAL})
            dest = 5'd31;
        else
            dest = is_j ? '0 : w[20:16];
        if (code inside {mips_decode_pkg::MTHI, mips_decode_pkg::MTLO, mips_decode_pkg::JR,
                         mips_decode_pkg::MULT, mips_decode_pkg::MULTU,
                         mips_decode_pkg::DIV, mips_decode_pkg::DIVU})
            we = 1'b0;
        else
            we = is_r || (code inside {mips_decode_pkg::JAL, mips_decode_pkg::BGEZAL,
                mips_decode_pkg::BLTZAL, mips_decode_pkg::LB, mips_decode_pkg::LBU,
                mips_decode_pkg::LH, mips_decode_pkg::LHU, mips_decode_pkg::LW,
                mips_decode_pkg::LWL, mips_decode_pkg::LWR, mips_decode_pkg::LUI,
                mips_decode_pkg::ADDI, mips_decode_pkg::ADDIU, mips_decode_pkg::ANDI,
                mips_decode_pkg::ORI, mips_decode_pkg::XORI, mips_decode_pkg::SLTI,
                mips_decode_pkg::SLTIU});
        we = we && (dest != 5'd0); // register 0 never written
    endtask

    // mostly legal words, the rest fully random
    function automatic mips_decode_pkg::instr_word_t random_word();
        mips_decode_pkg::instr_word_t w;
        int                           k;
        w = $urandom();
        if ($urandom_range(99) < 80) begin
            k = $urandom_range(52, 1);
            case (code_key[k][7:6])
                2'd0: w[31:26] = code_key[k][5:0];
                2'd1: begin
                    w[31:26] = `OPC_SPECIAL;
                    w[5:0]   = code_key[k][5:0];
                end
                default: begin
                    w[31:26] = `OPC_REGIMM;
                    w[20:16] = code_key[k][4:0];
                end
            endcase
        end
        return w;
    endfunction

    task automatic check_code(input string name, input mips_decode_pkg::instr_code_t exp,
                              input mips_decode_pkg::instr_code_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %s expected %h got %h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_reg(input string name, input mips_decode_pkg::reg_idx_t exp,
                             input mips_decode_pkg::reg_idx_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %s expected %h got %h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_imm(input string name, input mips_decode_pkg::imm_t exp,
                             input mips_decode_pkg::imm_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %s expected %h got %h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_target(input string name, input mips_decode_pkg::jump_target_t exp,
                                input mips_decode_pkg::jump_target_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %s expected %h got %h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %s expected %h got %h at %0t", name, exp, act, $time);
        end
    endtask

    // reference instruction register
    always @(posedge clk) begin
        if (!i_arst_n)
            model_ir = '0;
        else if (i_instr_valid)
            model_ir = i_instr;
    end

    // compare away from the driving edge
    always @(negedge clk) begin
        ref_decode(i_instr, e_code, e_rs, e_rt, e_shamt, e_dest, e_imm, e_target, e_we);
        check_code("o_code_1", e_code, o_code_1);
        check_reg("o_rs_1", e_rs, o_rs_1);
        check_reg("o_rt_1", e_rt, o_rt_1);
        check_imm("o_imm_1", e_imm, o_imm_1);
        check_target("o_jump_target", e_target, o_jump_target);
        ref_decode(model_ir, e_code, e_rs, e_rt, e_shamt, e_dest, e_imm, e_target, e_we);
        check_code("o_code_2", e_code, o_code_2);
        check_reg("o_rs_2", e_rs, o_rs_2);
        check_reg("o_rt_2", e_rt, o_rt_2);
        check_reg("o_shamt", e_shamt, o_shamt);
        check_imm("o_imm_2", e_imm, o_imm_2);
        check_reg("o_dest_reg", e_dest, o_dest_reg);
        check_bit("o_reg_write_en", e_we, o_reg_write_en);
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Regression failed");
        $finish;
    end

    initial begin
        i_arst_n      = 1'b0;
        i_instr       = '0;
        i_instr_valid = 1'b0;
        void'($urandom(SEED));
        repeat (RESET_CYCLES) @(posedge clk);
        i_arst_n <= 1'b1;
        repeat (NUM_CYCLES) begin
            @(posedge clk);
            i_instr       <= random_word();
            i_instr_valid <= ($urandom_range(99) < 70);
        end
        repeat (2) @(posedge clk); // the negedge in between compares the last word
        $display("done: %0d checks, %0d errors, %0d assertion failures",
                 checks, errors, uut.u_chk.fail_cnt);
        if (errors == 0 && uut.u_chk.fail_cnt == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule
